//--- hdl/sram_test_config.svh
`ifndef SRAM_TEST_CONFIG_SVH
`define SRAM_TEST_CONFIG_SVH

// SRAM geometry, 64 words of 16 bits
`define SRAM_ADDR_BITS 6
`define SRAM_DATA_BITS 16

// Access timing in clock cycles
`define SRAM_WRITE_CYCLES 2
`define SRAM_READ_CYCLES 2

// Wide enough for the longer of the two access counts
`define SRAM_CYCLE_BITS 4

`endif

//--- hdl/sram_test_pkg.sv
`include "sram_test_config.svh"

package sram_test_pkg;

  typedef logic [`SRAM_ADDR_BITS-1:0] addr_t;
  typedef logic [`SRAM_DATA_BITS-1:0] data_t;
  typedef logic [0:0] reg_idx_t;
  typedef logic [1:0] resp_t;

  // Register map of the configuration block
  localparam reg_idx_t REG_CTRL = 1'b0;
  localparam reg_idx_t REG_CUSTOM = 1'b1;

  localparam resp_t RESP_OKAY = 2'b00;

  // Applied in this order, one full write and read pass each
  typedef enum logic [2:0] {
    PAT_ZEROS,
    PAT_ONES,
    PAT_5555,
    PAT_AAAA,
    PAT_ADDR,
    PAT_CUSTOM
  } pattern_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE_REQ,
    ST_WRITE_WAIT,
    ST_READ_REQ,
    ST_READ_WAIT,
    ST_DONE
  } tester_state_t;

  typedef enum logic [1:0] {
    CS_IDLE,
    CS_WRITE,
    CS_READ,
    CS_RESP
  } ctrl_state_t;

endpackage

//--- hdl/pattern_generator.sv
`timescale 1ns/1ps
`include "sram_test_config.svh"

module pattern_generator (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           first_pattern,
  input  logic                           next_pattern,
  input  sram_test_pkg::addr_t           addr,
  input  sram_test_pkg::data_t           custom_pattern,
  output sram_test_pkg::data_t           pattern_word,
  output sram_test_pkg::pattern_t        current_pattern,
  output logic                           last_pattern
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      current_pattern <= sram_test_pkg::PAT_ZEROS;
    end else if (first_pattern) begin
      current_pattern <= sram_test_pkg::PAT_ZEROS;
    end else if (next_pattern && !last_pattern) begin
      current_pattern <= sram_test_pkg::pattern_t'(current_pattern + 3'd1);
    end
  end

  assign last_pattern = (current_pattern == sram_test_pkg::PAT_CUSTOM);

  // Word for the address currently presented by the tester
  always_comb begin
    case (current_pattern)
      sram_test_pkg::PAT_ZEROS: begin
        pattern_word = '0;
      end
      sram_test_pkg::PAT_ONES: begin
        pattern_word = '1;
      end
      sram_test_pkg::PAT_5555: begin
        pattern_word = sram_test_pkg::data_t'(16'h5555);
      end
      sram_test_pkg::PAT_AAAA: begin
        pattern_word = sram_test_pkg::data_t'(16'hAAAA);
      end
      sram_test_pkg::PAT_ADDR: begin
        // Zero-extended word address
        pattern_word = sram_test_pkg::data_t'(addr);
      end
      default: begin
        pattern_word = custom_pattern;
      end
    endcase
  end

endmodule

//--- hdl/axi_sram_controller.sv
`timescale 1ns/1ps
`include "sram_test_config.svh"

module axi_sram_controller (
  input  logic                        clk,
  input  logic                        reset,
  // Write address and data
  input  sram_test_pkg::addr_t        awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  sram_test_pkg::data_t        wdata,
  input  logic                        wvalid,
  output logic                        wready,
  // Write response
  output sram_test_pkg::resp_t        bresp,
  output logic                        bvalid,
  input  logic                        bready,
  // Read address and data
  input  sram_test_pkg::addr_t        araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output sram_test_pkg::data_t        rdata,
  output sram_test_pkg::resp_t        rresp,
  output logic                        rvalid,
  input  logic                        rready,
  // SRAM pins
  output sram_test_pkg::addr_t        sram_addr,
  inout  wire [`SRAM_DATA_BITS-1:0]   sram_data,
  output logic                        sram_we_n,
  output logic                        sram_oe_n,
  output logic                        sram_ce_n
);

  sram_test_pkg::ctrl_state_t  state;
  logic [`SRAM_CYCLE_BITS-1:0] cycle_cnt;
  logic                        drive_data;
  sram_test_pkg::data_t        wdata_q;
  logic                        write_accept;
  logic                        read_accept;
  logic                        write_last;
  logic                        read_last;
  logic                        resp_taken;

  // A write needs both channels at once and wins over a read
  assign write_accept = (state == sram_test_pkg::CS_IDLE) && awvalid && wvalid;
  assign read_accept  = (state == sram_test_pkg::CS_IDLE) && arvalid && !(awvalid && wvalid);

  assign awready = write_accept;
  assign wready  = write_accept;
  assign arready = read_accept;

  assign bresp = sram_test_pkg::RESP_OKAY;
  assign rresp = sram_test_pkg::RESP_OKAY;

  assign write_last = (state == sram_test_pkg::CS_WRITE) &&
                      (cycle_cnt == `SRAM_WRITE_CYCLES - 1);
  assign read_last  = (state == sram_test_pkg::CS_READ) &&
                      (cycle_cnt == `SRAM_READ_CYCLES - 1);
  assign resp_taken = (bvalid && bready) || (rvalid && rready);

  // Data stays on the bus through the response for hold time
  assign sram_data = drive_data ? wdata_q : {`SRAM_DATA_BITS{1'bz}};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= sram_test_pkg::CS_IDLE;
      cycle_cnt  <= '0;
      drive_data <= 1'b0;
      bvalid     <= 1'b0;
      rvalid     <= 1'b0;
      sram_we_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_ce_n  <= 1'b1;
    end else begin
      case (state)
        sram_test_pkg::CS_IDLE: begin
          cycle_cnt <= '0;
          if (write_accept) begin
            state      <= sram_test_pkg::CS_WRITE;
            drive_data <= 1'b1;
            sram_we_n  <= 1'b0;
            sram_ce_n  <= 1'b0;
          end else if (read_accept) begin
            state     <= sram_test_pkg::CS_READ;
            sram_oe_n <= 1'b0;
            sram_ce_n <= 1'b0;
          end
        end
        sram_test_pkg::CS_WRITE: begin
          if (write_last) begin
            state     <= sram_test_pkg::CS_RESP;
            sram_we_n <= 1'b1;
            sram_ce_n <= 1'b1;
            bvalid    <= 1'b1;
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        sram_test_pkg::CS_READ: begin
          if (read_last) begin
            state     <= sram_test_pkg::CS_RESP;
            sram_oe_n <= 1'b1;
            sram_ce_n <= 1'b1;
            rvalid    <= 1'b1;
          end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
          end
        end
        sram_test_pkg::CS_RESP: begin
          // Stalls here until the master takes the response
          if (resp_taken) begin
            state      <= sram_test_pkg::CS_IDLE;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
            drive_data <= 1'b0;
          end
        end
        default: begin
          state <= sram_test_pkg::CS_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (write_accept) begin
      sram_addr <= awaddr;
      wdata_q   <= wdata;
    end else if (read_accept) begin
      sram_addr <= araddr;
    end
    // Sample on the last cycle with oe_n low
    if (read_last) begin
      rdata <= sram_data;
    end
  end

endmodule

//--- hdl/sram_tester.sv
`timescale 1ns/1ps
`include "sram_test_config.svh"

module sram_tester (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  output logic                 busy,
  output logic                 done,
  output logic                 pass,
  output sram_test_pkg::addr_t fail_addr,
  output sram_test_pkg::data_t fail_read,
  output sram_test_pkg::data_t fail_expected,
  // Pattern generator
  output logic                 first_pattern,
  output logic                 next_pattern,
  output sram_test_pkg::addr_t addr,
  input  sram_test_pkg::data_t pattern_word,
  input  logic                 last_pattern,
  // AXI-Lite master
  output sram_test_pkg::addr_t awaddr,
  output logic                 awvalid,
  input  logic                 awready,
  output sram_test_pkg::data_t wdata,
  output logic                 wvalid,
  input  logic                 wready,
  input  sram_test_pkg::resp_t bresp,
  input  logic                 bvalid,
  output logic                 bready,
  output sram_test_pkg::addr_t araddr,
  output logic                 arvalid,
  input  logic                 arready,
  input  sram_test_pkg::data_t rdata,
  input  sram_test_pkg::resp_t rresp,
  input  logic                 rvalid,
  output logic                 rready
);

  sram_test_pkg::tester_state_t state;
  sram_test_pkg::data_t         expected;
  logic                         addr_last;
  logic                         write_resp;
  logic                         read_resp;
  logic                         write_bad;
  logic                         read_bad;

  // Responses are never back-pressured
  assign bready = 1'b1;
  assign rready = 1'b1;

  assign addr_last  = (addr == '1);
  assign write_resp = (state == sram_test_pkg::ST_WRITE_WAIT) && bvalid && bready;
  assign read_resp  = (state == sram_test_pkg::ST_READ_WAIT) && rvalid && rready;
  assign write_bad  = (bresp != sram_test_pkg::RESP_OKAY);
  assign read_bad   = (rdata != expected) || (rresp != sram_test_pkg::RESP_OKAY);

  assign first_pattern = start && !busy;
  assign next_pattern  = read_resp && !read_bad && addr_last && !last_pattern;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= sram_test_pkg::ST_IDLE;
      busy    <= 1'b0;
      done    <= 1'b0;
      pass    <= 1'b1;
      addr    <= '0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      arvalid <= 1'b0;
    end else begin
      case (state)
        sram_test_pkg::ST_IDLE, sram_test_pkg::ST_DONE: begin
          if (start) begin
            state <= sram_test_pkg::ST_WRITE_REQ;
            busy  <= 1'b1;
            done  <= 1'b0;
            pass  <= 1'b1;
            addr  <= '0;
          end
        end
        sram_test_pkg::ST_WRITE_REQ: begin
          awvalid <= 1'b1;
          wvalid  <= 1'b1;
          state   <= sram_test_pkg::ST_WRITE_WAIT;
        end
        sram_test_pkg::ST_WRITE_WAIT: begin
          if (awready) begin
            awvalid <= 1'b0;
          end
          if (wready) begin
            wvalid <= 1'b0;
          end
          if (write_resp) begin
            if (write_bad) begin
              state <= sram_test_pkg::ST_DONE;
              busy  <= 1'b0;
              done  <= 1'b1;
              pass  <= 1'b0;
            end else if (addr_last) begin
              // Array filled, start the read-back pass
              addr  <= '0;
              state <= sram_test_pkg::ST_READ_REQ;
            end else begin
              addr  <= addr + 1'b1;
              state <= sram_test_pkg::ST_WRITE_REQ;
            end
          end
        end
        sram_test_pkg::ST_READ_REQ: begin
          arvalid <= 1'b1;
          state   <= sram_test_pkg::ST_READ_WAIT;
        end
        sram_test_pkg::ST_READ_WAIT: begin
          if (arready) begin
            arvalid <= 1'b0;
          end
          if (read_resp) begin
            if (read_bad || (addr_last && last_pattern)) begin
              state <= sram_test_pkg::ST_DONE;
              busy  <= 1'b0;
              done  <= 1'b1;
              pass  <= !read_bad;
            end else if (addr_last) begin
              // Generator steps to the next pattern on this edge
              addr  <= '0;
              state <= sram_test_pkg::ST_WRITE_REQ;
            end else begin
              addr  <= addr + 1'b1;
              state <= sram_test_pkg::ST_READ_REQ;
            end
          end
        end
        default: begin
          state <= sram_test_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == sram_test_pkg::ST_WRITE_REQ) begin
      awaddr <= addr;
      wdata  <= pattern_word;
    end
    // Expected word is latched together with the read address
    if (state == sram_test_pkg::ST_READ_REQ) begin
      araddr   <= addr;
      expected <= pattern_word;
    end
    if (read_resp && read_bad) begin
      fail_addr     <= araddr;
      fail_read     <= rdata;
      fail_expected <= expected;
    end
    // A rejected write has no read data
    if (write_resp && write_bad) begin
      fail_addr     <= awaddr;
      fail_read     <= '0;
      fail_expected <= wdata;
    end
  end

endmodule

//--- hdl/tester_regs.sv
`timescale 1ns/1ps
`include "sram_test_config.svh"

module tester_regs (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cfg_valid,
  output logic                    cfg_ready,
  input  sram_test_pkg::reg_idx_t cfg_idx,
  input  sram_test_pkg::data_t    cfg_wdata,
  input  logic                    busy,
  output logic                    start,
  output sram_test_pkg::data_t    custom_pattern
);

  logic cfg_write;

  // Also closed during the start cycle, before busy has risen
  assign cfg_ready = !busy && !start;
  assign cfg_write = cfg_valid && cfg_ready;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= cfg_write && (cfg_idx == sram_test_pkg::REG_CTRL) && cfg_wdata[0];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      custom_pattern <= '0;
    end else if (cfg_write && (cfg_idx == sram_test_pkg::REG_CUSTOM)) begin
      custom_pattern <= cfg_wdata;
    end
  end

endmodule

//--- hdl/sram_test_top.sv
`timescale 1ns/1ps
`include "sram_test_config.svh"

module sram_test_top (
  input  logic                       clk,
  input  logic                       reset,
  // Configuration port
  input  logic                       cfg_valid,
  output logic                       cfg_ready,
  input  logic                       cfg_idx,
  input  logic [`SRAM_DATA_BITS-1:0] cfg_wdata,
  // Status
  output logic                       busy,
  output logic                       done,
  output logic                       pass,
  output logic [`SRAM_ADDR_BITS-1:0] fail_addr,
  output logic [`SRAM_DATA_BITS-1:0] fail_read,
  output logic [`SRAM_DATA_BITS-1:0] fail_expected,
  output logic [2:0]                 current_pattern,
  // SRAM pins
  output logic [`SRAM_ADDR_BITS-1:0] sram_addr,
  inout  wire  [`SRAM_DATA_BITS-1:0] sram_data,
  output logic                       sram_we_n,
  output logic                       sram_oe_n,
  output logic                       sram_ce_n
);

  logic                       start;
  logic [`SRAM_DATA_BITS-1:0] custom_pattern;

  logic                       first_pattern;
  logic                       next_pattern;
  logic                       last_pattern;
  logic [`SRAM_ADDR_BITS-1:0] addr;
  logic [`SRAM_DATA_BITS-1:0] pattern_word;

  // AXI-Lite between tester and controller
  logic [`SRAM_ADDR_BITS-1:0] awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [`SRAM_DATA_BITS-1:0] wdata;
  logic                       wvalid;
  logic                       wready;
  logic [1:0]                 bresp;
  logic                       bvalid;
  logic                       bready;
  logic [`SRAM_ADDR_BITS-1:0] araddr;
  logic                       arvalid;
  logic                       arready;
  logic [`SRAM_DATA_BITS-1:0] rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready;

  tester_regs regs_i (
    .clk            (clk),
    .reset          (reset),
    .cfg_valid      (cfg_valid),
    .cfg_ready      (cfg_ready),
    .cfg_idx        (cfg_idx),
    .cfg_wdata      (cfg_wdata),
    .busy           (busy),
    .start          (start),
    .custom_pattern (custom_pattern)
  );

  pattern_generator pattern_i (
    .clk             (clk),
    .reset           (reset),
    .first_pattern   (first_pattern),
    .next_pattern    (next_pattern),
    .addr            (addr),
    .custom_pattern  (custom_pattern),
    .pattern_word    (pattern_word),
    .current_pattern (current_pattern),
    .last_pattern    (last_pattern)
  );

  sram_tester tester_i (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .busy          (busy),
    .done          (done),
    .pass          (pass),
    .fail_addr     (fail_addr),
    .fail_read     (fail_read),
    .fail_expected (fail_expected),
    .first_pattern (first_pattern),
    .next_pattern  (next_pattern),
    .addr          (addr),
    .pattern_word  (pattern_word),
    .last_pattern  (last_pattern),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wvalid        (wvalid),
    .wready        (wready),
    .bresp         (bresp),
    .bvalid        (bvalid),
    .bready        (bready),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready)
  );

  axi_sram_controller ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

endmodule

//--- dv/sram_model.sv
`timescale 1ns/1ps
`include "sram_test_config.svh"

module sram_model (
  input  logic [`SRAM_ADDR_BITS-1:0] sram_addr,
  inout  wire  [`SRAM_DATA_BITS-1:0] sram_data,
  input  logic                       sram_we_n,
  input  logic                       sram_oe_n,
  input  logic                       sram_ce_n,
  // Fault injection, mask 0 means a healthy array
  input  logic [`SRAM_ADDR_BITS-1:0] stuck_addr,
  input  logic [`SRAM_DATA_BITS-1:0] stuck_mask
);

  logic [`SRAM_DATA_BITS-1:0] mem [0:(1<<`SRAM_ADDR_BITS)-1];
  logic [`SRAM_DATA_BITS-1:0] read_word;

  // Power-up contents differ per address
  initial begin
    for (int i = 0; i < (1 << `SRAM_ADDR_BITS); i++) begin
      mem[i] = `SRAM_DATA_BITS'(i * 16'h0401) ^ `SRAM_DATA_BITS'(16'h9E37);
    end
  end

  // Level-sensitive write while the chip is selected and we_n is low
  always @(sram_we_n or sram_ce_n or sram_addr or sram_data) begin
    if (!sram_ce_n && !sram_we_n) begin
      mem[sram_addr] = sram_data;
    end
  end

  // Stuck-at-one cells show up on the read path only
  assign read_word = mem[sram_addr] | ((sram_addr == stuck_addr) ? stuck_mask : '0);

  assign sram_data = (!sram_ce_n && !sram_oe_n && sram_we_n) ?
                     read_word : {`SRAM_DATA_BITS{1'bz}};

endmodule

//--- dv/sram_test_sva.sv
`timescale 1ns/1ps

module sram_test_sva (
  input logic clk,
  input logic reset,
  input logic sram_we_n,
  input logic sram_oe_n,
  input logic sram_ce_n,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready
);

  // Never drive and read the data pins at once
  assert property (@(posedge clk) disable iff (reset) !(!sram_we_n && !sram_oe_n))
    else $error("sram_we_n and sram_oe_n are low together");

  assert property (@(posedge clk) disable iff (reset)
                   (!sram_we_n || !sram_oe_n) |-> !sram_ce_n)
    else $error("sram_ce_n is high during an SRAM access");

  // Responses hold until taken and are not repeated
  assert property (@(posedge clk) disable iff (reset)
                   bvalid |=> ($past(bready) ? !bvalid : bvalid))
    else $error("bvalid not held until bready or repeated after it");

  assert property (@(posedge clk) disable iff (reset)
                   rvalid |=> ($past(rready) ? !rvalid : rvalid))
    else $error("rvalid not held until rready or repeated after it");

endmodule

bind axi_sram_controller sram_test_sva sva_i (
  .clk       (clk),
  .reset     (reset),
  .sram_we_n (sram_we_n),
  .sram_oe_n (sram_oe_n),
  .sram_ce_n (sram_ce_n),
  .bvalid    (bvalid),
  .bready    (bready),
  .rvalid    (rvalid),
  .rready    (rready)
);

//--- dv/sram_test_tb.sv
`timescale 1ns/1ps
`include "sram_test_config.svh"

module sram_test_tb;

  localparam int NUM_CASES = 8;
  localparam int FIELDS = 8;
  localparam int RUN_TIMEOUT = 20000;
  localparam int BUSY_TIMEOUT = 20;
  localparam int LAST_PATTERN = 5;

  logic                       clk = 1'b0;
  logic                       reset;
  logic                       cfg_valid;
  logic                       cfg_ready;
  logic                       cfg_idx;
  logic [`SRAM_DATA_BITS-1:0] cfg_wdata;
  logic                       busy;
  logic                       done;
  logic                       pass;
  logic [`SRAM_ADDR_BITS-1:0] fail_addr;
  logic [`SRAM_DATA_BITS-1:0] fail_read;
  logic [`SRAM_DATA_BITS-1:0] fail_expected;
  logic [2:0]                 current_pattern;
  logic [`SRAM_ADDR_BITS-1:0] sram_addr;
  wire  [`SRAM_DATA_BITS-1:0] sram_data;
  logic                       sram_we_n;
  logic                       sram_oe_n;
  logic                       sram_ce_n;

  // Fault seen by the model, armed from a given pattern onwards
  logic [`SRAM_ADDR_BITS-1:0] fault_addr;
  logic [`SRAM_DATA_BITS-1:0] fault_mask;
  logic [2:0]                 fault_arm;
  logic [`SRAM_DATA_BITS-1:0] active_mask;

  logic [15:0] testdata [0:NUM_CASES*FIELDS-1];
  int          errors;
  bit          aborted;
  int          done_rises = 0;
  logic        done_q = 1'b0;

  always #10 clk = ~clk;

  assign active_mask = (current_pattern >= fault_arm) ? fault_mask : '0;

  sram_test_top dut_i (
    .clk             (clk),
    .reset           (reset),
    .cfg_valid       (cfg_valid),
    .cfg_ready       (cfg_ready),
    .cfg_idx         (cfg_idx),
    .cfg_wdata       (cfg_wdata),
    .busy            (busy),
    .done            (done),
    .pass            (pass),
    .fail_addr       (fail_addr),
    .fail_read       (fail_read),
    .fail_expected   (fail_expected),
    .current_pattern (current_pattern),
    .sram_addr       (sram_addr),
    .sram_data       (sram_data),
    .sram_we_n       (sram_we_n),
    .sram_oe_n       (sram_oe_n),
    .sram_ce_n       (sram_ce_n)
  );

  sram_model sram_i (
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n),
    .stuck_addr (fault_addr),
    .stuck_mask (active_mask)
  );

  // Counts rising edges of done
  always @(negedge clk) begin
    done_q <= done;
    if (done && !done_q) begin
      done_rises <= done_rises + 1;
    end
  end

  always @(negedge clk) begin
    if (!reset) begin
      assert (!(busy && cfg_ready)) else begin
        $display("FAILED at %0t: cfg_ready is high while busy", $time);
        errors++;
      end
    end
  end

  function automatic logic [15:0] pattern_value(input int pat, input int addr,
                                                input logic [15:0] custom);
    case (pat)
      0: return 16'h0000;
      1: return 16'hFFFF;
      2: return 16'h5555;
      3: return 16'hAAAA;
      4: return 16'(addr);
      default: return custom;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Holds cfg_valid until the register block takes the write
  task automatic write_cfg(input logic idx, input logic [15:0] data,
                           output int waited, output bit ok);
    @(negedge clk);
    cfg_valid = 1'b1;
    cfg_idx = idx;
    cfg_wdata = data;
    waited = 0;
    while (!cfg_ready && waited < RUN_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    ok = cfg_ready;
    @(negedge clk);
    cfg_valid = 1'b0;
    if (!ok) begin
      $display("Timed out waiting for cfg_ready to accept a register write");
      aborted = 1'b1;
    end
  endtask

  task automatic start_run(output bit ok);
    int waited;
    int cycles;
    write_cfg(1'b0, 16'h0001, waited, ok);
    cycles = 0;
    while (ok && !busy && cycles < BUSY_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (ok && !busy) begin
      $display("Timed out waiting for busy after a start command");
      aborted = 1'b1;
      ok = 1'b0;
    end
  endtask

  task automatic finish_run(output bit ok);
    int cycles;
    cycles = 0;
    while (!done && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    ok = done;
    if (!ok) begin
      $display("Timed out waiting for done at the end of a run");
      aborted = 1'b1;
    end
  endtask

  task automatic check_results(input int base, input logic [15:0] custom);
    logic [15:0] expected;
    int          fpat;
    int          faddr;
    fpat = testdata[base+6];
    faddr = testdata[base+7];
    check_value("pass", pass, testdata[base+5][0]);
    if (testdata[base+5][0]) begin
      check_value("current_pattern at end of run", current_pattern, LAST_PATTERN);
    end else begin
      expected = pattern_value(fpat, faddr, custom);
      check_value("failing pattern", current_pattern, fpat);
      check_value("fail_addr", fail_addr, faddr);
      check_value("fail_expected", fail_expected, expected);
      check_value("fail_read", fail_read, expected | testdata[base+3]);
    end
  endtask

  task automatic reset_mid_run(output bit ok);
    int cycles;
    start_run(ok);
    cycles = 0;
    while (ok && current_pattern != 3'd2 && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (ok && current_pattern != 3'd2) begin
      $display("Timed out waiting for the run to reach the third pattern");
      aborted = 1'b1;
      ok = 1'b0;
    end
    if (ok) begin
      check_value("busy before reset", busy, 1);
      reset = 1'b1;
      repeat (2) @(negedge clk);
      check_value("busy in reset", busy, 0);
      check_value("done in reset", done, 0);
      check_value("cfg_ready in reset", cfg_ready, 1);
      check_value("pass in reset", pass, 1);
      reset = 1'b0;
      @(negedge clk);
      check_value("busy after reset", busy, 0);
    end
  endtask

  initial begin
    int          base;
    int          mode;
    int          runs;
    int          waited;
    int          rises_before;
    int          errors_before;
    int          clean_cases;
    bit          ok;
    logic [15:0] custom;
    reset = 1'b1;
    cfg_valid = 1'b0;
    cfg_idx = 1'b0;
    cfg_wdata = '0;
    fault_addr = '0;
    fault_mask = '0;
    fault_arm = '0;
    errors = 0;
    aborted = 1'b0;
    clean_cases = 0;
    $readmemh("dv/sram_testdata.txt", testdata);
    if ($isunknown(testdata[0])) begin
      $display("Could not read the test data file");
      aborted = 1'b1;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;
    check_value("cfg_ready after reset", cfg_ready, 1);
    check_value("pass after reset", pass, 1);
    for (int i = 0; i < NUM_CASES && !aborted; i++) begin
      base = i * FIELDS;
      mode = testdata[base];
      custom = testdata[base+1];
      errors_before = errors;
      fault_mask = '0;
      ok = 1'b1;
      if (mode == 1) begin
        // The new custom value must wait for the running test to end
        start_run(ok);
        if (ok) begin
          write_cfg(1'b1, custom, waited, ok);
          check_value("cfg write held through a run", waited > 0, 1);
          check_value("done at cfg accept", done, 1);
          check_value("pass of the fault-free run", pass, 1);
        end
      end else begin
        write_cfg(1'b1, custom, waited, ok);
      end
      if (ok) begin
        fault_addr = testdata[base+2][`SRAM_ADDR_BITS-1:0];
        fault_mask = testdata[base+3];
        fault_arm = testdata[base+4][2:0];
      end
      if (ok && mode == 3) begin
        reset_mid_run(ok);
      end else if (ok) begin
        runs = (mode == 2) ? 2 : 1;
        for (int r = 0; r < runs && ok; r++) begin
          rises_before = done_rises;
          start_run(ok);
          if (ok) begin
            finish_run(ok);
          end
          if (ok) begin
            repeat (4) @(negedge clk);
            check_value("done pulses in one run", done_rises - rises_before, 1);
            check_results(base, custom);
          end
        end
      end
      if (ok && errors == errors_before) begin
        clean_cases++;
      end
      $display("case %0d mode %0d finished with %0d errors", i, mode, errors - errors_before);
    end
    $display("%0d of %0d cases clean, %0d errors", clean_cases, NUM_CASES, errors);
    if (errors == 0 && !aborted) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+hdl
hdl/sram_test_pkg.sv
hdl/pattern_generator.sv
hdl/axi_sram_controller.sv
hdl/sram_tester.sv
hdl/tester_regs.sv
hdl/sram_test_top.sv
dv/sram_model.sv
dv/sram_test_sva.sv
dv/sram_test_tb.sv

//--- dv/sram_testdata.txt
// mode custom stuck_addr stuck_mask arm_pattern exp_pass exp_fail_pattern exp_fail_addr
// mode 0 one run, 1 custom written during a busy run, 2 two runs back to back, 3 reset mid-run
0 1234 00 0000 0 1 0 00
0 BEEF 00 0000 0 1 0 00
0 0F0F 2A 0010 0 0 0 2A
0 FFFE 15 0001 5 0 5 15
1 7FFF 3C 8000 5 0 5 3C
2 C3A5 00 0000 0 1 0 00
3 5A5A 00 0000 0 1 0 00
0 FFFF 3F 0100 4 0 4 3F
